/* source/serial_pkg.sv */
`default_nettype none

package serial_pkg;

    // operand word width, one shift register bit per operand bit
    parameter int DEFAULT_WIDTH = 16;

    // cycles from the last serialized bit to the output register
    // one in the ALU register, one into the output register
    parameter int STAGE_LATENCY = 2;

endpackage

`default_nettype wire

/* source/alu_op_pkg.sv */
`default_nettype none

package alu_op_pkg;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_XOR  = 3'd2,
        OP_AND  = 3'd3,
        OP_NOT  = 3'd4,  // b is ignored
        OP_OR   = 3'd5,
        OP_NOR  = 3'd6,
        OP_NAND = 3'd7
    } alu_op_t;

    // ops that go through the full adder and carry register
    function automatic logic is_arith(alu_op_t op);
        return (op == OP_ADD) || (op == OP_SUB);
    endfunction

endpackage

`default_nettype wire

/* source/operand_shifter.sv */
`default_nettype none

module operand_shifter #(
    parameter int WIDTH = 16
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  in_valid,
    input  alu_op_pkg::alu_op_t  op,
    input  wire [WIDTH-1:0]      a,
    input  wire [WIDTH-1:0]      b,
    input  wire                  stall,
    output logic                 in_ready,
    output logic                 bit_valid,
    output logic                 bit_first,
    output logic                 bit_last,
    output logic                 a_bit,
    output logic                 b_bit,
    output alu_op_pkg::alu_op_t  bit_op
);

    localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic                busy;
    logic [CNT_W-1:0]    cnt;
    logic [WIDTH-1:0]    sh_a;
    logic [WIDTH-1:0]    sh_b;
    alu_op_pkg::alu_op_t op_q;
    logic                accept;
    logic                shift;
    logic                cnt_last;

    assign in_ready = ~busy;
    assign accept   = in_valid & ~busy;
    assign shift    = busy & ~stall;
    assign cnt_last = (cnt == CNT_W'(WIDTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            cnt       <= '0;
            bit_valid <= 1'b0;
            bit_first <= 1'b0;
            bit_last  <= 1'b0;
        end else if (!busy) begin
            if (!stall) begin  // last bit taken, nothing new on the line
                bit_valid <= 1'b0;
                bit_first <= 1'b0;
                bit_last  <= 1'b0;
            end
            if (in_valid) begin
                busy <= 1'b1;
                cnt  <= '0;
            end
        end else if (!stall) begin
            bit_valid <= 1'b1;
            bit_first <= (cnt == '0);
            bit_last  <= cnt_last;
            cnt       <= cnt + 1'b1;
            if (cnt_last)
                busy <= 1'b0;  // idle while the last bit goes out
        end
    end

    // operand shift registers, LSB leaves first
    always_ff @(posedge clk) begin
        if (accept) begin
            sh_a <= a;
            sh_b <= b;
            op_q <= op;
        end else if (shift) begin
            sh_a <= sh_a >> 1;
            sh_b <= sh_b >> 1;
        end
    end

    // op travels with each bit so a new request cannot disturb a stalled last bit
    always_ff @(posedge clk) begin
        if (shift) begin
            a_bit  <= sh_a[0];
            b_bit  <= sh_b[0];
            bit_op <= op_q;
        end
    end

    // while idle the only bit on the line is the last one of the finished word
    a_idle_only_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        bit_valid && !busy |-> bit_last
    ) else $error("bit_valid high while idle outside the last bit");

endmodule

`default_nettype wire

/* source/serial_alu.sv */
`default_nettype none

module serial_alu (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  stall,
    input  wire                  bit_valid,
    input  wire                  bit_first,
    input  wire                  bit_last,
    input  wire                  a_bit,
    input  wire                  b_bit,
    input  alu_op_pkg::alu_op_t  bit_op,
    output logic                 res_valid,
    output logic                 res_bit,
    output logic                 res_last,
    output logic                 res_carry,
    output logic                 res_arith
);

    logic carry_q;
    logic sub;
    logic arith;
    logic b_eff;
    logic c_in;
    logic sum;
    logic c_out;
    logic fn;
    logic step;

    assign sub   = (bit_op == alu_op_pkg::OP_SUB);
    assign arith = alu_op_pkg::is_arith(bit_op);
    assign step  = bit_valid & ~stall;

    // subtract is a plus inverted b plus one
    assign b_eff = b_bit ^ sub;
    assign c_in  = bit_first ? sub : carry_q;  // preset on first bit

    assign sum   = a_bit ^ b_eff ^ c_in;
    assign c_out = (a_bit & b_eff) | (c_in & (a_bit ^ b_eff));

    always_comb begin
        case (bit_op)
            alu_op_pkg::OP_ADD,
            alu_op_pkg::OP_SUB:  fn = sum;
            alu_op_pkg::OP_XOR:  fn = a_bit ^ b_bit;
            alu_op_pkg::OP_AND:  fn = a_bit & b_bit;
            alu_op_pkg::OP_NOT:  fn = ~a_bit;
            alu_op_pkg::OP_OR:   fn = a_bit | b_bit;
            alu_op_pkg::OP_NOR:  fn = ~(a_bit | b_bit);
            alu_op_pkg::OP_NAND: fn = ~(a_bit & b_bit);
            default:             fn = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res_last  <= 1'b0;
            carry_q   <= 1'b0;
        end else if (!stall) begin
            res_valid <= bit_valid;
            res_last  <= bit_valid & bit_last;
            if (bit_valid)
                carry_q <= c_out;  // carried into the next bit
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            res_bit   <= fn;
            res_carry <= c_out;  // only meaningful with res_last
            res_arith <= arith;
        end
    end

    // framing flags from stage 1 never come without a bit
    a_flags_need_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        (bit_first || bit_last) |-> bit_valid
    ) else $error("bit_first or bit_last without bit_valid");

endmodule

`default_nettype wire

/* source/result_shifter.sv */
`default_nettype none

module result_shifter #(
    parameter int WIDTH = 16
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              res_valid,
    input  wire              res_bit,
    input  wire              res_last,
    input  wire              res_carry,
    input  wire              res_arith,
    input  wire              out_ready,
    output logic             stall,
    output logic             out_valid,
    output logic [WIDTH-1:0] result,
    output logic             carry,
    output logic             zero
);

    logic [WIDTH-1:0] asm_q;
    logic [WIDTH-1:0] word;
    logic             take;
    logic             load;

    // last bit joins at the top, earlier bits already sit below it
    assign word = {res_bit, asm_q[WIDTH-1:1]};

    // full output and a finished word waiting behind it
    assign stall = out_valid & ~out_ready & res_valid & res_last;

    assign take = res_valid & ~stall;
    assign load = take & res_last;

    always_ff @(posedge clk) begin
        if (take)
            asm_q <= word;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (load)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            result <= word;
            carry  <= res_carry & res_arith;  // logic ops report no carry
            zero   <= ~|word;
        end
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=>
            out_valid && $stable(result) && $stable(carry) && $stable(zero)
    ) else $error("response changed while waiting for out_ready");

endmodule

`default_nettype wire

/* source/serial_alu_top.sv */
`default_nettype none

module serial_alu_top #(
    parameter int WIDTH = serial_pkg::DEFAULT_WIDTH
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  in_valid,
    input  alu_op_pkg::alu_op_t  op,
    input  wire [WIDTH-1:0]      a,
    input  wire [WIDTH-1:0]      b,
    output logic                 in_ready,
    output logic                 out_valid,
    output logic [WIDTH-1:0]     result,
    output logic                 carry,
    output logic                 zero,
    input  wire                  out_ready
);

    // stage 1 to stage 2
    logic                bit_valid;
    logic                bit_first;
    logic                bit_last;
    logic                a_bit;
    logic                b_bit;
    alu_op_pkg::alu_op_t bit_op;

    // stage 2 to stage 3
    logic                res_valid;
    logic                res_bit;
    logic                res_last;
    logic                res_carry;
    logic                res_arith;

    logic                stall;  // back-pressure from the output register

    operand_shifter #(
        .WIDTH(WIDTH)
    ) operand_shifter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .stall     (stall),
        .in_ready  (in_ready),
        .bit_valid (bit_valid),
        .bit_first (bit_first),
        .bit_last  (bit_last),
        .a_bit     (a_bit),
        .b_bit     (b_bit),
        .bit_op    (bit_op)
    );

    serial_alu serial_alu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .bit_valid (bit_valid),
        .bit_first (bit_first),
        .bit_last  (bit_last),
        .a_bit     (a_bit),
        .b_bit     (b_bit),
        .bit_op    (bit_op),
        .res_valid (res_valid),
        .res_bit   (res_bit),
        .res_last  (res_last),
        .res_carry (res_carry),
        .res_arith (res_arith)
    );

    result_shifter #(
        .WIDTH(WIDTH)
    ) result_shifter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res_bit   (res_bit),
        .res_last  (res_last),
        .res_carry (res_carry),
        .res_arith (res_arith),
        .out_ready (out_ready),
        .stall     (stall),
        .out_valid (out_valid),
        .result    (result),
        .carry     (carry),
        .zero      (zero)
    );

endmodule

`default_nettype wire

/* tests/tb_ref.svh */
`ifndef TB_REF_SVH
`define TB_REF_SVH

// expected response for one request
typedef struct packed {
    logic [WIDTH-1:0] result;
    logic             carry;
    logic             zero;
} exp_t;

function automatic exp_t ref_alu(
    input alu_op_pkg::alu_op_t op_i,
    input logic [WIDTH-1:0]    a_i,
    input logic [WIDTH-1:0]    b_i
);
    logic [WIDTH:0] wide;  // one extra bit for the carry out
    exp_t           e;
    wide    = '0;
    e.carry = 1'b0;
    case (op_i)
        alu_op_pkg::OP_ADD: begin
            wide     = {1'b0, a_i} + {1'b0, b_i};
            e.result = wide[WIDTH-1:0];
            e.carry  = wide[WIDTH];
        end
        alu_op_pkg::OP_SUB: begin
            wide     = {1'b0, a_i} - {1'b0, b_i};
            e.result = wide[WIDTH-1:0];
            e.carry  = (a_i >= b_i);  // set when nothing is borrowed
        end
        alu_op_pkg::OP_XOR:  e.result = a_i ^ b_i;
        alu_op_pkg::OP_AND:  e.result = a_i & b_i;
        alu_op_pkg::OP_NOT:  e.result = ~a_i;
        alu_op_pkg::OP_OR:   e.result = a_i | b_i;
        alu_op_pkg::OP_NOR:  e.result = ~(a_i | b_i);
        alu_op_pkg::OP_NAND: e.result = ~(a_i & b_i);
        default:             e.result = '0;
    endcase
    e.zero = (e.result == '0);
    return e;
endfunction

function automatic string op_name(input alu_op_pkg::alu_op_t op_i);
    case (op_i)
        alu_op_pkg::OP_ADD:  return "add";
        alu_op_pkg::OP_SUB:  return "sub";
        alu_op_pkg::OP_XOR:  return "xor";
        alu_op_pkg::OP_AND:  return "and";
        alu_op_pkg::OP_NOT:  return "not";
        alu_op_pkg::OP_OR:   return "or";
        alu_op_pkg::OP_NOR:  return "nor";
        alu_op_pkg::OP_NAND: return "nand";
        default:             return "unknown";
    endcase
endfunction

`endif

/* tests/tb_serial_alu.sv */
`default_nettype none

module tb_serial_alu;

    localparam int WIDTH   = serial_pkg::DEFAULT_WIDTH;
    localparam int LATENCY = WIDTH + serial_pkg::STAGE_LATENCY;  // accept edge to out_valid
    localparam int N_ADD   = 100;
    localparam int N_SUB   = 60;
    localparam int N_LOGIC = 10;  // per logic op
    localparam int N_BP    = 80;
    localparam int N_REQ   = N_ADD + 2 + N_SUB + 2 + 6 * N_LOGIC + 1 + N_BP;
    localparam int TIMEOUT = 40 * N_REQ + 200;

    `include "tb_ref.svh"

    typedef struct packed {
        alu_op_pkg::alu_op_t op;
        logic [WIDTH-1:0]    a;
        logic [WIDTH-1:0]    b;
    } req_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                in_valid;
    alu_op_pkg::alu_op_t op;
    logic [WIDTH-1:0]    a;
    logic [WIDTH-1:0]    b;
    logic                in_ready;
    logic                out_valid;
    logic [WIDTH-1:0]    result;
    logic                carry;
    logic                zero;
    logic                out_ready = 1'b1;
    logic                bp_on = 1'b0;  // random out_ready when set

    integer seed    = 32;
    int     cyc     = 0;
    int     acc_cyc = 0;
    int     err_cnt = 0;
    int     chk_cnt = 0;
    int     req_cnt = 0;
    int     resp_cnt = 0;

    req_t                sb_q[$];
    req_t                bp_reqs[N_BP];
    alu_op_pkg::alu_op_t logic_ops[6];

    // held response, for the stability check
    logic             hold_prev = 1'b0;
    logic [WIDTH-1:0] hold_result;
    logic             hold_carry;
    logic             hold_zero;

    serial_alu_top #(
        .WIDTH(WIDTH)
    ) serial_alu_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .result    (result),
        .carry     (carry),
        .zero      (zero),
        .out_ready (out_ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // mostly low, so a response often waits long enough to stall the pipe
    always @(posedge clk) begin
        logic [31:0] rnd;
        if (bp_on) begin
            rnd = $random(seed);
            out_ready <= (rnd[3:0] == 4'd0);
        end else begin
            out_ready <= 1'b1;
        end
    end

    function automatic logic [WIDTH-1:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[WIDTH-1:0];
    endfunction

    task automatic note_err(input string msg);
        err_cnt++;
        $display("ERR @%0t: %s", $time, msg);
    endtask

    // called on a rising edge, returns on the accepting edge
    task automatic send_req(input alu_op_pkg::alu_op_t op_i, input logic [WIDTH-1:0] a_i,
                            input logic [WIDTH-1:0] b_i);
        req_t r;
        r.op = op_i;
        r.a  = a_i;
        r.b  = b_i;
        in_valid <= 1'b1;
        op       <= op_i;
        a        <= a_i;
        b        <= b_i;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        sb_q.push_back(r);
        req_cnt++;
        acc_cyc = cyc + 1;
        @(posedge clk);
    endtask

    task automatic wait_drain();
        while (sb_q.size() != 0)
            @(negedge clk);
        @(posedge clk);
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (err_cnt == err_before)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, err_cnt - err_before);
    endtask

    // scoreboard, a response transfers on the next rising edge
    always @(negedge clk) begin
        req_t req;
        exp_t want;
        if (rst_n) begin
            if (hold_prev) begin
                chk_cnt++;
                if (!out_valid || result !== hold_result || carry !== hold_carry ||
                    zero !== hold_zero)
                    note_err("response changed while out_ready was low");
            end
            if (out_valid && out_ready) begin
                if (sb_q.size() == 0) begin
                    note_err("response with no request pending");
                end else begin
                    req  = sb_q.pop_front();
                    want = ref_alu(req.op, req.a, req.b);
                    resp_cnt++;
                    chk_cnt++;
                    if (result !== want.result)
                        note_err($sformatf("%s a=%h b=%h result %h expected %h",
                            op_name(req.op), req.a, req.b, result, want.result));
                    if (carry !== want.carry)
                        note_err($sformatf("%s a=%h b=%h carry %b expected %b",
                            op_name(req.op), req.a, req.b, carry, want.carry));
                    if (zero !== want.zero)
                        note_err($sformatf("%s a=%h b=%h zero %b expected %b",
                            op_name(req.op), req.a, req.b, zero, want.zero));
                end
            end
            hold_prev   = out_valid && !out_ready;
            hold_result = result;
            hold_carry  = carry;
            hold_zero   = zero;
        end
    end

    initial begin
        while (cyc < TIMEOUT)
            @(negedge clk);
        $display("run stopped: not finished within %0d cycles", TIMEOUT);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int               e0;
        logic [31:0]      rv;
        logic [WIDTH-1:0] w;
        rst_n    <= 1'b0;
        in_valid <= 1'b0;
        op       <= alu_op_pkg::OP_ADD;
        a        <= '0;
        b        <= '0;
        logic_ops[0] = alu_op_pkg::OP_XOR;
        logic_ops[1] = alu_op_pkg::OP_AND;
        logic_ops[2] = alu_op_pkg::OP_NOT;
        logic_ops[3] = alu_op_pkg::OP_OR;
        logic_ops[4] = alu_op_pkg::OP_NOR;
        logic_ops[5] = alu_op_pkg::OP_NAND;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        e0 = err_cnt;
        repeat (3) begin
            @(negedge clk);
            chk_cnt++;
            if (!in_ready || out_valid)
                note_err("in_ready low or out_valid high after reset");
        end
        report_test(1, "reset state", e0);
        @(posedge clk);

        e0 = err_cnt;
        send_req(alu_op_pkg::OP_ADD, '1, WIDTH'(1));  // wraps to zero with carry
        send_req(alu_op_pkg::OP_ADD, '0, '0);
        repeat (N_ADD) send_req(alu_op_pkg::OP_ADD, rand_word(), rand_word());
        in_valid <= 1'b0;
        wait_drain();
        report_test(2, "add", e0);

        e0 = err_cnt;
        w = rand_word();
        send_req(alu_op_pkg::OP_SUB, w, w);
        send_req(alu_op_pkg::OP_SUB, WIDTH'(5), WIDTH'(9));
        repeat (N_SUB) send_req(alu_op_pkg::OP_SUB, rand_word(), rand_word());
        in_valid <= 1'b0;
        wait_drain();
        report_test(3, "sub", e0);

        e0 = err_cnt;
        foreach (logic_ops[i]) begin
            repeat (N_LOGIC) send_req(logic_ops[i], rand_word(), rand_word());
        end
        in_valid <= 1'b0;
        wait_drain();
        report_test(4, "logic ops", e0);

        e0 = err_cnt;
        send_req(alu_op_pkg::OP_ADD, rand_word(), rand_word());
        in_valid <= 1'b0;
        @(negedge clk);
        while (!out_valid)
            @(negedge clk);
        chk_cnt++;
        if (cyc - acc_cyc != LATENCY)
            note_err($sformatf("out_valid after %0d cycles, expected %0d",
                cyc - acc_cyc, LATENCY));
        wait_drain();
        report_test(5, "latency", e0);

        // operands drawn up front so out_ready owns the random stream later
        e0 = err_cnt;
        foreach (bp_reqs[i]) begin
            rv = $random(seed);
            bp_reqs[i].op = alu_op_pkg::alu_op_t'(rv[2:0]);
            bp_reqs[i].a  = rand_word();
            bp_reqs[i].b  = rand_word();
        end
        bp_on <= 1'b1;
        foreach (bp_reqs[i]) begin
            send_req(bp_reqs[i].op, bp_reqs[i].a, bp_reqs[i].b);
        end
        in_valid <= 1'b0;
        bp_on    <= 1'b0;
        wait_drain();
        // a repeated response would reach the scoreboard within one latency
        repeat (LATENCY) @(posedge clk);
        report_test(6, "back-pressure", e0);

        $display("requests %0d responses %0d checks %0d errors %0d",
            req_cnt, resp_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+tests
source/serial_pkg.sv
source/alu_op_pkg.sv
source/operand_shifter.sv
source/serial_alu.sv
source/result_shifter.sv
source/serial_alu_top.sv
tests/tb_serial_alu.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_serial_alu -f all.f -o tb_serial_alu > build.log 2>&1 \
    && ./obj_dir/tb_serial_alu > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
if grep -q '^\*\*\* FAILED \*\*\*$' sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation clean"
exit 0
